/* src/mipsCtrlPkg.sv */
package mipsCtrlPkg;

    localparam int OP_WIDTH       = 6;
    localparam int FUNCT_WIDTH    = 6;
    localparam int REG_ADDR_WIDTH = 5;

    // rt value on the shared REGIMM opcode that means bgez
    localparam logic [REG_ADDR_WIDTH-1:0] RT_BGEZ = 5'b00001;

    typedef enum logic [OP_WIDTH-1:0] {
        OP_RTYPE  = 6'b000000,   // Also jr and jalr
        OP_REGIMM = 6'b000001,   // bltz / bgez, chosen by rt
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LB     = 6'b100000,
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_LBU    = 6'b100100,
        OP_LHU    = 6'b100101,
        OP_SB     = 6'b101000,
        OP_SH     = 6'b101001,
        OP_SW     = 6'b101011
    } opcode_e;

    typedef enum logic [FUNCT_WIDTH-1:0] {
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        S_INITIAL,
        S_FETCH,
        S_DECODE,
        S_MEM_ADDR,
        S_MEM_LOAD,
        S_MEM_STORE,
        S_LOAD_DONE,
        S_EXECUTE,
        S_ALU_DONE,
        S_BRANCH,
        S_JUMP
    } ctrlState_e;

    typedef enum logic [2:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP_IMM,
        CLS_JUMP_REG,
        CLS_ILLEGAL
    } instrClass_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_LUI, ALU_BNE, ALU_BLTZ, ALU_BGEZ, ALU_BGTZ, ALU_BLEZ
    } aluOp_e;

    typedef enum logic [2:0] {MEMR_WORD, MEMR_HALF, MEMR_HALFU, MEMR_BYTE, MEMR_BYTEU} memRSize_e;
    typedef enum logic [1:0] {MEMW_WORD, MEMW_HALF, MEMW_BYTE} memWSize_e;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDst_e;
    typedef enum logic [1:0] {M2R_MEM, M2R_ALU, M2R_PC4} memToReg_e;
    typedef enum logic [1:0] {SRCA_REG, SRCA_PC} aluSrcA_e;
    typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM, SRCB_IMM_SH2} aluSrcB_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_REGA} pcSrc_e;

endpackage

/* src/instrDecoder.sv */
`timescale 1ns/1ns

module instrDecoder
    import mipsCtrlPkg::*;
(
    input  logic [OP_WIDTH-1:0]       op,
    input  logic [FUNCT_WIDTH-1:0]    funct,
    input  logic [REG_ADDR_WIDTH-1:0] rt,
    output instrClass_e               instrClass,
    output aluOp_e                    instrAluOp,
    output aluSrcB_e                  instrAluSrcB,
    output regDst_e                   instrRegDst,
    output memRSize_e                 instrMemRSize,
    output memWSize_e                 instrMemWSize,
    output logic                      instrLinks
);

    always_comb
    begin
        instrClass    = CLS_ILLEGAL;
        instrAluOp    = ALU_ADD;
        instrAluSrcB  = SRCB_REG;
        instrRegDst   = DST_RT;
        instrMemRSize = MEMR_WORD;
        instrMemWSize = MEMW_WORD;
        instrLinks    = 1'b0;

        case (op)
            OP_RTYPE:
            begin
                instrClass  = CLS_ALU_REG;
                instrRegDst = DST_RD;
                case (funct)
                    FN_ADD, FN_ADDU: instrAluOp = ALU_ADD;
                    FN_SUB, FN_SUBU: instrAluOp = ALU_SUB;
                    FN_AND:          instrAluOp = ALU_AND;
                    FN_OR:           instrAluOp = ALU_OR;
                    FN_XOR:          instrAluOp = ALU_XOR;
                    FN_NOR:          instrAluOp = ALU_NOR;
                    FN_SLT:          instrAluOp = ALU_SLT;
                    FN_SLTU:         instrAluOp = ALU_SLTU;
                    FN_JR:           instrClass = CLS_JUMP_REG;
                    FN_JALR:
                    begin
                        instrClass  = CLS_JUMP_REG;
                        instrRegDst = DST_RA;   // Return address to r31
                        instrLinks  = 1'b1;
                    end
                    default:         instrClass = CLS_ILLEGAL;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU:
            begin
                instrClass   = CLS_ALU_IMM;
                instrAluSrcB = SRCB_IMM;
                case (op)
                    OP_ANDI:  instrAluOp = ALU_AND;
                    OP_ORI:   instrAluOp = ALU_OR;
                    OP_XORI:  instrAluOp = ALU_XOR;
                    OP_LUI:   instrAluOp = ALU_LUI;
                    OP_SLTI:  instrAluOp = ALU_SLT;
                    OP_SLTIU: instrAluOp = ALU_SLTU;
                    default:  instrAluOp = ALU_ADD;
                endcase
            end
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU:
            begin
                instrClass   = CLS_LOAD;
                instrAluSrcB = SRCB_IMM;
                case (op)
                    OP_LH:   instrMemRSize = MEMR_HALF;
                    OP_LHU:  instrMemRSize = MEMR_HALFU;
                    OP_LB:   instrMemRSize = MEMR_BYTE;
                    OP_LBU:  instrMemRSize = MEMR_BYTEU;
                    default: instrMemRSize = MEMR_WORD;
                endcase
            end
            OP_SW, OP_SH, OP_SB:
            begin
                instrClass   = CLS_STORE;
                instrAluSrcB = SRCB_IMM;
                case (op)
                    OP_SH:   instrMemWSize = MEMW_HALF;
                    OP_SB:   instrMemWSize = MEMW_BYTE;
                    default: instrMemWSize = MEMW_WORD;
                endcase
            end
            OP_BEQ:  {instrClass, instrAluOp} = {CLS_BRANCH, ALU_SUB};
            OP_BNE:  {instrClass, instrAluOp} = {CLS_BRANCH, ALU_BNE};
            OP_BGTZ: {instrClass, instrAluOp} = {CLS_BRANCH, ALU_BGTZ};
            OP_BLEZ: {instrClass, instrAluOp} = {CLS_BRANCH, ALU_BLEZ};
            OP_REGIMM:
            begin
                instrClass = CLS_BRANCH;
                instrAluOp = (rt == RT_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
            end
            OP_J:    instrClass = CLS_JUMP_IMM;
            OP_JAL:
            begin
                instrClass  = CLS_JUMP_IMM;
                instrRegDst = DST_RA;
                instrLinks  = 1'b1;
            end
            default: instrClass = CLS_ILLEGAL;
        endcase
    end

endmodule

/* src/ctrlSequencer.sv */
`timescale 1ns/1ns

module ctrlSequencer
    import mipsCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  instrClass_e instrClass,
    output ctrlState_e  state
);

    ctrlState_e nextState;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            state <= S_INITIAL;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = S_INITIAL;
        case (state)
            S_INITIAL:   nextState = S_FETCH;
            S_FETCH:     nextState = S_DECODE;
            S_DECODE:
            begin
                case (instrClass)
                    CLS_ALU_REG, CLS_ALU_IMM:   nextState = S_EXECUTE;
                    CLS_LOAD, CLS_STORE:        nextState = S_MEM_ADDR;
                    CLS_BRANCH:                 nextState = S_BRANCH;
                    CLS_JUMP_IMM, CLS_JUMP_REG: nextState = S_JUMP;
                    default:                    nextState = S_INITIAL;   // Illegal
                endcase
            end
            S_MEM_ADDR:
            begin
                if (instrClass == CLS_LOAD)
                    nextState = S_MEM_LOAD;
                else if (instrClass == CLS_STORE)
                    nextState = S_MEM_STORE;
                else
                    nextState = S_INITIAL;
            end
            S_MEM_LOAD:  nextState = S_LOAD_DONE;
            S_LOAD_DONE: nextState = S_FETCH;
            S_MEM_STORE: nextState = S_FETCH;
            S_EXECUTE:   nextState = S_ALU_DONE;
            S_ALU_DONE:  nextState = S_FETCH;
            S_BRANCH:    nextState = S_FETCH;
            S_JUMP:      nextState = S_FETCH;
            default:     nextState = S_INITIAL;
        endcase
    end

    stateKnown: assert property (@(posedge clk) rstN |-> !$isunknown(state))
        else $error("FSM state unknown out of reset");

    // Unknown instructions fall back through Initial before the next fetch
    illegalToInitial: assert property (@(posedge clk) disable iff (!rstN)
        (state == S_DECODE && instrClass == CLS_ILLEGAL) |=> state == S_INITIAL)
        else $error("Illegal instruction did not return to Initial");

endmodule

/* src/ctrlOutputs.sv */
`timescale 1ns/1ns

module ctrlOutputs
    import mipsCtrlPkg::*;
(
    input  ctrlState_e  state,
    input  instrClass_e instrClass,
    input  aluOp_e      instrAluOp,
    input  aluSrcB_e    instrAluSrcB,
    input  regDst_e     instrRegDst,
    input  memRSize_e   instrMemRSize,
    input  memWSize_e   instrMemWSize,
    input  logic        instrLinks,
    output logic        pcWrite,
    output logic        pcWriteCond,
    output logic        irWrite,
    output logic        regWrite,
    output logic        memRead,
    output logic        memWrite,
    output aluOp_e      aluOp,
    output aluSrcA_e    aluSrcA,
    output aluSrcB_e    aluSrcB,
    output pcSrc_e      pcSrc,
    output regDst_e     regDst,
    output memToReg_e   memToReg,
    output memRSize_e   memRSize,
    output memWSize_e   memWSize
);

    always_comb
    begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        aluOp       = ALU_ADD;
        aluSrcA     = SRCA_REG;
        aluSrcB     = SRCB_REG;
        pcSrc       = PC_PLUS4;
        regDst      = DST_RT;
        memToReg    = M2R_ALU;
        memRSize    = MEMR_WORD;
        memWSize    = MEMW_WORD;

        case (state)
            S_FETCH:
            begin
                pcWrite = 1'b1;
                irWrite = 1'b1;
                aluSrcA = SRCA_PC;
                aluSrcB = SRCB_FOUR;   // PC+4
            end
            S_DECODE:
            begin
                aluSrcA = SRCA_PC;
                aluSrcB = SRCB_IMM_SH2;   // Branch target precompute
            end
            S_MEM_ADDR:  aluSrcB = SRCB_IMM;
            S_MEM_LOAD:
            begin
                memRead  = 1'b1;
                memRSize = instrMemRSize;
            end
            S_MEM_STORE:
            begin
                memWrite = 1'b1;
                memWSize = instrMemWSize;
            end
            S_LOAD_DONE:
            begin
                regWrite = 1'b1;
                memToReg = M2R_MEM;
            end
            S_EXECUTE:
            begin
                aluSrcB = instrAluSrcB;
                aluOp   = instrAluOp;
            end
            S_ALU_DONE:
            begin
                regWrite = 1'b1;
                regDst   = instrRegDst;
            end
            S_BRANCH:
            begin
                pcWriteCond = 1'b1;
                pcSrc       = PC_BRANCH;
                aluOp       = instrAluOp;   // Compare of rs with rt or zero
            end
            S_JUMP:
            begin
                pcWrite  = 1'b1;
                pcSrc    = (instrClass == CLS_JUMP_REG) ? PC_REGA : PC_JUMP;
                regWrite = instrLinks;
                regDst   = instrRegDst;
                memToReg = M2R_PC4;
            end
            default:
            begin
                // Initial keeps all defaults
            end
        endcase
    end

    always_comb
    begin
        memExclusive: assert final (!(memRead && memWrite))
            else $error("memRead and memWrite both high");
        pcExclusive: assert final (!(pcWrite && pcWriteCond))
            else $error("pcWrite and pcWriteCond both high");
    end

endmodule

/* src/mipsCtrl.sv */
`timescale 1ns/1ns

module mipsCtrl
    import mipsCtrlPkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [OP_WIDTH-1:0]       op,
    input  logic [FUNCT_WIDTH-1:0]    funct,
    input  logic [REG_ADDR_WIDTH-1:0] rt,
    output logic                      pcWrite,
    output logic                      pcWriteCond,
    output logic                      irWrite,
    output logic                      regWrite,
    output logic                      memRead,
    output logic                      memWrite,
    output aluOp_e                    aluOp,
    output aluSrcA_e                  aluSrcA,
    output aluSrcB_e                  aluSrcB,
    output pcSrc_e                    pcSrc,
    output regDst_e                   regDst,
    output memToReg_e                 memToReg,
    output memRSize_e                 memRSize,
    output memWSize_e                 memWSize
);

    instrClass_e instrClass;
    aluOp_e      instrAluOp;
    aluSrcB_e    instrAluSrcB;
    regDst_e     instrRegDst;
    memRSize_e   instrMemRSize;
    memWSize_e   instrMemWSize;
    logic        instrLinks;
    ctrlState_e  state;

    instrDecoder instrDecoder_inst (
        .op            (op),
        .funct         (funct),
        .rt            (rt),
        .instrClass    (instrClass),
        .instrAluOp    (instrAluOp),
        .instrAluSrcB  (instrAluSrcB),
        .instrRegDst   (instrRegDst),
        .instrMemRSize (instrMemRSize),
        .instrMemWSize (instrMemWSize),
        .instrLinks    (instrLinks)
    );

    ctrlSequencer ctrlSequencer_inst (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .state      (state)
    );

    ctrlOutputs ctrlOutputs_inst (
        .state         (state),
        .instrClass    (instrClass),
        .instrAluOp    (instrAluOp),
        .instrAluSrcB  (instrAluSrcB),
        .instrRegDst   (instrRegDst),
        .instrMemRSize (instrMemRSize),
        .instrMemWSize (instrMemWSize),
        .instrLinks    (instrLinks),
        .pcWrite       (pcWrite),
        .pcWriteCond   (pcWriteCond),
        .irWrite       (irWrite),
        .regWrite      (regWrite),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .aluOp         (aluOp),
        .aluSrcA       (aluSrcA),
        .aluSrcB       (aluSrcB),
        .pcSrc         (pcSrc),
        .regDst        (regDst),
        .memToReg      (memToReg),
        .memRSize      (memRSize),
        .memWSize      (memWSize)
    );

endmodule

/* tb/ctrlChecks.svh */
`ifndef CTRL_CHECKS_SVH
`define CTRL_CHECKS_SVH

int errCount = 0;
int timeoutCount = 0;

task automatic checkBit(input string name, input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: %s expected %0b, actual %0b", name, what, exp, act);
    end
endtask

// Order is pcWrite, pcWriteCond, irWrite, regWrite, memRead, memWrite
task automatic checkStrobes(input string name, input logic [5:0] exp);
    checkBit(name, "pcWrite", exp[5], pcWrite);
    checkBit(name, "pcWriteCond", exp[4], pcWriteCond);
    checkBit(name, "irWrite", exp[3], irWrite);
    checkBit(name, "regWrite", exp[2], regWrite);
    checkBit(name, "memRead", exp[1], memRead);
    checkBit(name, "memWrite", exp[0], memWrite);
endtask

task automatic checkAluOp(input string name, input aluOp_e exp, input aluOp_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: aluOp expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic checkAluSrcA(input string name, input aluSrcA_e exp, input aluSrcA_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: aluSrcA expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic checkAluSrcB(input string name, input aluSrcB_e exp, input aluSrcB_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: aluSrcB expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic checkPcSrc(input string name, input pcSrc_e exp, input pcSrc_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: pcSrc expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic checkRegDst(input string name, input regDst_e exp, input regDst_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: regDst expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic checkMemToReg(input string name, input memToReg_e exp, input memToReg_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: memToReg expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic checkMemRSize(input string name, input memRSize_e exp, input memRSize_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: memRSize expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

task automatic checkMemWSize(input string name, input memWSize_e exp, input memWSize_e act);
    if (act !== exp)
    begin
        errCount++;
        $display("[FAIL] %s: memWSize expected %s, actual %s", name, exp.name(), act.name());
    end
endtask

`endif

/* tb/mipsCtrlTb.sv */
`timescale 1ns/1ns

module mipsCtrlTb
    import mipsCtrlPkg::*;
();

    localparam int FETCH_TIMEOUT = 20;   // Cycles

    logic                      clk;
    logic                      rstN;
    logic [OP_WIDTH-1:0]       op;
    logic [FUNCT_WIDTH-1:0]    funct;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic                      pcWrite;
    logic                      pcWriteCond;
    logic                      irWrite;
    logic                      regWrite;
    logic                      memRead;
    logic                      memWrite;
    aluOp_e                    aluOp;
    aluSrcA_e                  aluSrcA;
    aluSrcB_e                  aluSrcB;
    pcSrc_e                    pcSrc;
    regDst_e                   regDst;
    memToReg_e                 memToReg;
    memRSize_e                 memRSize;
    memWSize_e                 memWSize;

    `include "ctrlChecks.svh"

    mipsCtrl mipsCtrl_inst (
        .clk         (clk),
        .rstN        (rstN),
        .op          (op),
        .funct       (funct),
        .rt          (rt),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .aluOp       (aluOp),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .pcSrc       (pcSrc),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .memRSize    (memRSize),
        .memWSize    (memWSize)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [FUNCT_WIDTH-1:0] randFunct();
        return $urandom_range(2**FUNCT_WIDTH-1, 0);
    endfunction

    function automatic logic [REG_ADDR_WIDTH-1:0] randRt();
        return $urandom_range(2**REG_ADDR_WIDTH-1, 0);
    endfunction

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d timeouts", errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    task automatic waitFetch(input string name);
        int cycles;
        cycles = 0;
        while (irWrite !== 1'b1 && cycles < FETCH_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (irWrite !== 1'b1)
        begin
            timeoutCount++;
            $display("Timeout: %s never reached an instruction fetch", name);
        end
    endtask

    task automatic checkFetch(input string name);
        checkStrobes({name, "/fetch"}, 6'b101000);
        checkAluOp({name, "/fetch"}, ALU_ADD, aluOp);
        checkAluSrcA({name, "/fetch"}, SRCA_PC, aluSrcA);
        checkAluSrcB({name, "/fetch"}, SRCB_FOUR, aluSrcB);
        checkPcSrc({name, "/fetch"}, PC_PLUS4, pcSrc);
    endtask

    // Walks the expected cycle sequence of one instruction, Fetch to next Fetch
    task automatic runInstr(input string name, input instrClass_e cls,
            input logic [OP_WIDTH-1:0] newOp, input logic [FUNCT_WIDTH-1:0] newFunct,
            input logic [REG_ADDR_WIDTH-1:0] newRt, input aluOp_e expOp,
            input aluSrcB_e expSrcB, input regDst_e expDst,
            input memRSize_e expRSize, input memWSize_e expWSize);
        logic   links;
        pcSrc_e expPc;
        if (timeoutCount != 0)
            return;
        waitFetch(name);
        if (timeoutCount != 0)
            return;
        checkFetch(name);
        op = newOp;
        funct = newFunct;
        rt = newRt;
        @(negedge clk);
        checkStrobes({name, "/decode"}, 6'b000000);
        checkAluOp({name, "/decode"}, ALU_ADD, aluOp);
        checkAluSrcA({name, "/decode"}, SRCA_PC, aluSrcA);
        checkAluSrcB({name, "/decode"}, SRCB_IMM_SH2, aluSrcB);
        case (cls)
            CLS_ALU_REG, CLS_ALU_IMM:
            begin
                @(negedge clk);
                checkStrobes({name, "/execute"}, 6'b000000);
                checkAluOp({name, "/execute"}, expOp, aluOp);
                checkAluSrcA({name, "/execute"}, SRCA_REG, aluSrcA);
                checkAluSrcB({name, "/execute"}, expSrcB, aluSrcB);
                @(negedge clk);
                checkStrobes({name, "/aluDone"}, 6'b000100);
                checkRegDst({name, "/aluDone"}, expDst, regDst);
                checkMemToReg({name, "/aluDone"}, M2R_ALU, memToReg);
            end
            CLS_LOAD, CLS_STORE:
            begin
                @(negedge clk);
                checkStrobes({name, "/memAddr"}, 6'b000000);
                checkAluOp({name, "/memAddr"}, ALU_ADD, aluOp);
                checkAluSrcA({name, "/memAddr"}, SRCA_REG, aluSrcA);
                checkAluSrcB({name, "/memAddr"}, SRCB_IMM, aluSrcB);
                @(negedge clk);
                if (cls == CLS_LOAD)
                begin
                    checkStrobes({name, "/memLoad"}, 6'b000010);
                    checkMemRSize({name, "/memLoad"}, expRSize, memRSize);
                    @(negedge clk);
                    checkStrobes({name, "/loadDone"}, 6'b000100);
                    checkRegDst({name, "/loadDone"}, DST_RT, regDst);
                    checkMemToReg({name, "/loadDone"}, M2R_MEM, memToReg);
                end
                else
                begin
                    checkStrobes({name, "/memStore"}, 6'b000001);
                    checkMemWSize({name, "/memStore"}, expWSize, memWSize);
                end
            end
            CLS_BRANCH:
            begin
                @(negedge clk);
                checkStrobes({name, "/branch"}, 6'b010000);
                checkPcSrc({name, "/branch"}, PC_BRANCH, pcSrc);
                checkAluOp({name, "/branch"}, expOp, aluOp);
                checkAluSrcA({name, "/branch"}, SRCA_REG, aluSrcA);
                checkAluSrcB({name, "/branch"}, SRCB_REG, aluSrcB);
            end
            CLS_JUMP_IMM, CLS_JUMP_REG:
            begin
                links = (expDst == DST_RA);   // Only jal and jalr write r31
                if (cls == CLS_JUMP_REG)
                    expPc = PC_REGA;
                else
                    expPc = PC_JUMP;
                @(negedge clk);
                checkStrobes({name, "/jump"}, {3'b100, links, 2'b00});
                checkPcSrc({name, "/jump"}, expPc, pcSrc);
                if (links)
                begin
                    checkRegDst({name, "/jump"}, DST_RA, regDst);
                    checkMemToReg({name, "/jump"}, M2R_PC4, memToReg);
                end
            end
            default:
            begin
                @(negedge clk);
                checkStrobes({name, "/initial"}, 6'b000000);
            end
        endcase
        @(negedge clk);
        checkBit({name, "/next fetch"}, "irWrite", 1'b1, irWrite);
    endtask

    task automatic runAluReg(input string name, input funct_e newFunct, input aluOp_e expOp);
        runInstr(name, CLS_ALU_REG, OP_RTYPE, newFunct, randRt(), expOp, SRCB_REG, DST_RD,
            MEMR_WORD, MEMW_WORD);
    endtask

    task automatic runAluImm(input string name, input opcode_e newOp, input aluOp_e expOp);
        runInstr(name, CLS_ALU_IMM, newOp, randFunct(), randRt(), expOp, SRCB_IMM, DST_RT,
            MEMR_WORD, MEMW_WORD);
    endtask

    task automatic runLoad(input string name, input opcode_e newOp, input memRSize_e expSize);
        runInstr(name, CLS_LOAD, newOp, randFunct(), randRt(), ALU_ADD, SRCB_IMM, DST_RT,
            expSize, MEMW_WORD);
    endtask

    task automatic runStore(input string name, input opcode_e newOp, input memWSize_e expSize);
        runInstr(name, CLS_STORE, newOp, randFunct(), randRt(), ALU_ADD, SRCB_IMM, DST_RT,
            MEMR_WORD, expSize);
    endtask

    task automatic runBranch(input string name, input opcode_e newOp,
            input logic [REG_ADDR_WIDTH-1:0] newRt, input aluOp_e expOp);
        runInstr(name, CLS_BRANCH, newOp, randFunct(), newRt, expOp, SRCB_REG, DST_RT,
            MEMR_WORD, MEMW_WORD);
    endtask

    task automatic testReset();
        int i;
        rstN = 1'b0;
        for (i = 0; i < 5; i++)
        begin
            @(negedge clk);
            checkStrobes("reset", 6'b000000);
        end
        rstN = 1'b1;
        @(negedge clk);   // One rising edge later
        checkFetch("reset");
    endtask

    task automatic testArith();
        runAluReg("add", FN_ADD, ALU_ADD);
        runAluReg("addu", FN_ADDU, ALU_ADD);
        runAluReg("sub", FN_SUB, ALU_SUB);
        runAluReg("subu", FN_SUBU, ALU_SUB);
        runAluReg("and", FN_AND, ALU_AND);
        runAluReg("or", FN_OR, ALU_OR);
        runAluReg("xor", FN_XOR, ALU_XOR);
        runAluReg("nor", FN_NOR, ALU_NOR);
        runAluReg("slt", FN_SLT, ALU_SLT);
        runAluReg("sltu", FN_SLTU, ALU_SLTU);
        runAluImm("addi", OP_ADDI, ALU_ADD);
        runAluImm("addiu", OP_ADDIU, ALU_ADD);
        runAluImm("andi", OP_ANDI, ALU_AND);
        runAluImm("ori", OP_ORI, ALU_OR);
        runAluImm("xori", OP_XORI, ALU_XOR);
        runAluImm("lui", OP_LUI, ALU_LUI);
        runAluImm("slti", OP_SLTI, ALU_SLT);
        runAluImm("sltiu", OP_SLTIU, ALU_SLTU);
    endtask

    task automatic testMemory();
        runLoad("lw", OP_LW, MEMR_WORD);
        runLoad("lh", OP_LH, MEMR_HALF);
        runLoad("lhu", OP_LHU, MEMR_HALFU);
        runLoad("lb", OP_LB, MEMR_BYTE);
        runLoad("lbu", OP_LBU, MEMR_BYTEU);
        runStore("sw", OP_SW, MEMW_WORD);
        runStore("sh", OP_SH, MEMW_HALF);
        runStore("sb", OP_SB, MEMW_BYTE);
    endtask

    task automatic testBranches();
        runBranch("beq", OP_BEQ, randRt(), ALU_SUB);
        runBranch("bne", OP_BNE, randRt(), ALU_BNE);
        runBranch("bgtz", OP_BGTZ, randRt(), ALU_BGTZ);
        runBranch("blez", OP_BLEZ, randRt(), ALU_BLEZ);
        runBranch("bgez", OP_REGIMM, RT_BGEZ, ALU_BGEZ);
        runBranch("bltz", OP_REGIMM, 5'b00000, ALU_BLTZ);
        runBranch("bltz rt 2", OP_REGIMM, 5'b00010, ALU_BLTZ);
    endtask

    task automatic testJumps();
        runInstr("j", CLS_JUMP_IMM, OP_J, randFunct(), randRt(), ALU_ADD, SRCB_REG, DST_RT,
            MEMR_WORD, MEMW_WORD);
        runInstr("jal", CLS_JUMP_IMM, OP_JAL, randFunct(), randRt(), ALU_ADD, SRCB_REG, DST_RA,
            MEMR_WORD, MEMW_WORD);
        runInstr("jr", CLS_JUMP_REG, OP_RTYPE, FN_JR, randRt(), ALU_ADD, SRCB_REG, DST_RT,
            MEMR_WORD, MEMW_WORD);
        runInstr("jalr", CLS_JUMP_REG, OP_RTYPE, FN_JALR, randRt(), ALU_ADD, SRCB_REG, DST_RA,
            MEMR_WORD, MEMW_WORD);
    endtask

    task automatic testIllegal();
        runInstr("bad opcode", CLS_ILLEGAL, 6'b111111, randFunct(), randRt(), ALU_ADD,
            SRCB_REG, DST_RT, MEMR_WORD, MEMW_WORD);
        runInstr("bad funct", CLS_ILLEGAL, OP_RTYPE, 6'b111111, randRt(), ALU_ADD,
            SRCB_REG, DST_RT, MEMR_WORD, MEMW_WORD);
    endtask

    initial
    begin
        void'($urandom(58));
        rstN = 1'b0;
        op = OP_RTYPE;
        funct = FN_ADD;
        rt = '0;
        testReset();
        testArith();
        testMemory();
        testBranches();
        testJumps();
        testIllegal();
        finishRun();
    end

endmodule

/* flist.f */
+incdir+tb
src/mipsCtrlPkg.sv
src/instrDecoder.sv
src/ctrlSequencer.sv
src/ctrlOutputs.sv
src/mipsCtrl.sv
tb/mipsCtrlTb.sv
